// File: source/desc_proc_config.svh
`ifndef DESC_PROC_CONFIG_SVH
`define DESC_PROC_CONFIG_SVH

// --------------------------------------------------
// Bus geometry
// --------------------------------------------------
`define DP_DATA_W            32

// --------------------------------------------------
// MAC register map
// --------------------------------------------------
`define DP_MAC_BASE          32'h6000_0000
`define DP_ASYNC_CAUSE_OFS   32'h0000_4038
`define DP_ISR_OFS           32'h0000_0080

// Cause and status bits
`define DP_INTR_MAC_IRQ      32'h0000_0002
// High- and low-priority receive OK
`define DP_ISR_RXOK_MASK     32'h0000_0003

// --------------------------------------------------
// Receive descriptor layout
// --------------------------------------------------
`define DP_RXS_STATUS11_OFS  32'd44
`define DP_RXS_FCTL_OFS      32'd48
`define DP_RX_DONE           32'h0000_0001

// Frame control, tested in the low half of its word
`define DP_FCTL_TYPE_MASK    16'h00FC
`define DP_FCTL_TDMA         16'h0004

`endif

// File: source/desc_proc_pkg.sv
`include "desc_proc_config.svh"

package desc_proc_pkg;

    // One address or data word on the simple bus
    typedef logic [`DP_DATA_W-1:0] bus_word_t;

    // --------------------------------------------------
    // Transmit write-back FSM
    // --------------------------------------------------
    typedef enum logic [2:0] {
        TX_IDLE,
        TX_ADDR_POP,
        TX_DATA_WAIT,
        TX_DATA_POP,
        TX_WRITE
    } tx_state_t;

    // --------------------------------------------------
    // Interrupt filter FSM
    // --------------------------------------------------
    typedef enum logic [2:0] {
        IRQ_IDLE,
        IRQ_CAUSE,
        IRQ_ISR,
        IRQ_PEEK,
        IRQ_STATUS,
        IRQ_FCTL,
        IRQ_POP,
        IRQ_PASS
    } irq_state_t;

endpackage

// File: source/bus_if.sv
`timescale 1ns/1ps

// One master's view of the simple request/complete bus
interface bus_if;

    logic                   req;
    logic                   write;
    desc_proc_pkg::bus_word_t addr;
    desc_proc_pkg::bus_word_t wdata;
    // Valid in the cycle of done
    desc_proc_pkg::bus_word_t rdata;
    logic                   done;

    modport initiator (
        output req,
        output write,
        output addr,
        output wdata,
        input  rdata,
        input  done
    );

    modport target (
        input  req,
        input  write,
        input  addr,
        input  wdata,
        output rdata,
        output done
    );

endinterface

// File: source/bus_arbiter.sv
`timescale 1ns/1ps

module bus_arbiter (
    input  logic                     clk,
    input  logic                     reset_n,
    bus_if.target                    tx_port,
    bus_if.target                    irq_port,
    output logic                     bus_req,
    output logic                     bus_write,
    output desc_proc_pkg::bus_word_t bus_addr,
    output desc_proc_pkg::bus_word_t bus_wdata,
    input  desc_proc_pkg::bus_word_t bus_rdata,
    input  logic                     bus_cmplt
);

    logic grant_valid;
    // Which port owns the bus, 1 means the interrupt filter
    logic grant_irq;
    // Port served by the most recent grant
    logic last_irq;
    logic pick_irq;

    // --------------------------------------------------
    // Round-robin choice while idle
    // --------------------------------------------------
    always_comb begin
        if (tx_port.req && irq_port.req) begin
            pick_irq = !last_irq;
        end else begin
            pick_irq = irq_port.req;
        end
    end

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            grant_valid <= 1'b0;
            grant_irq   <= 1'b0;
            last_irq    <= 1'b0;
        end else if (!grant_valid) begin
            if (tx_port.req || irq_port.req) begin
                grant_valid <= 1'b1;
                grant_irq   <= pick_irq;
                last_irq    <= pick_irq;
            end
        end else if (bus_cmplt) begin
            // Owner drops req on the same edge
            grant_valid <= 1'b0;
        end
    end

    // --------------------------------------------------
    // External side follows the granted port
    // --------------------------------------------------
    always_comb begin
        if (grant_irq) begin
            bus_req   = grant_valid && irq_port.req;
            bus_write = irq_port.write;
            bus_addr  = irq_port.addr;
            bus_wdata = irq_port.wdata;
        end else begin
            bus_req   = grant_valid && tx_port.req;
            bus_write = tx_port.write;
            bus_addr  = tx_port.addr;
            bus_wdata = tx_port.wdata;
        end
    end

    // Completion and read data go back to the owner only
    assign tx_port.done   = grant_valid && !grant_irq && bus_cmplt;
    assign irq_port.done  = grant_valid && grant_irq && bus_cmplt;
    assign tx_port.rdata  = (grant_valid && !grant_irq) ? bus_rdata : '0;
    assign irq_port.rdata = (grant_valid && grant_irq) ? bus_rdata : '0;

endmodule

// File: source/tx_desc_writer.sv
`timescale 1ns/1ps

module tx_desc_writer (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     fifo_empty,
    input  desc_proc_pkg::bus_word_t fifo_data,
    output logic                     fifo_rd_en,
    bus_if.initiator                 bus
);

    desc_proc_pkg::tx_state_t state;
    logic                     req_q;
    desc_proc_pkg::bus_word_t addr_q;
    desc_proc_pkg::bus_word_t data_q;

    // --------------------------------------------------
    // FIFO pop and write sequencing
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state      <= desc_proc_pkg::TX_IDLE;
            fifo_rd_en <= 1'b0;
            req_q      <= 1'b0;
        end else begin
            // rd_en is a single-cycle pulse
            fifo_rd_en <= 1'b0;
            case (state)
                desc_proc_pkg::TX_IDLE: begin
                    // First-word fall-through, head word is already visible
                    if (!fifo_empty) begin
                        fifo_rd_en <= 1'b1;
                        state      <= desc_proc_pkg::TX_ADDR_POP;
                    end
                end
                desc_proc_pkg::TX_ADDR_POP: begin
                    // FIFO advances at the end of this cycle
                    state <= desc_proc_pkg::TX_DATA_WAIT;
                end
                desc_proc_pkg::TX_DATA_WAIT: begin
                    if (!fifo_empty) begin
                        fifo_rd_en <= 1'b1;
                        state      <= desc_proc_pkg::TX_DATA_POP;
                    end
                end
                desc_proc_pkg::TX_DATA_POP: begin
                    req_q <= 1'b1;
                    state <= desc_proc_pkg::TX_WRITE;
                end
                desc_proc_pkg::TX_WRITE: begin
                    // Nothing more is popped until the write lands
                    if (bus.done) begin
                        req_q <= 1'b0;
                        state <= desc_proc_pkg::TX_IDLE;
                    end
                end
                default: begin
                    state <= desc_proc_pkg::TX_IDLE;
                end
            endcase
        end
    end

    // Captured payload words
    always_ff @(posedge clk) begin
        if (state == desc_proc_pkg::TX_IDLE && !fifo_empty) begin
            addr_q <= fifo_data;
        end
        if (state == desc_proc_pkg::TX_DATA_WAIT && !fifo_empty) begin
            data_q <= fifo_data;
        end
    end

    // Always full-word writes
    assign bus.req   = req_q;
    assign bus.write = 1'b1;
    assign bus.addr  = addr_q;
    assign bus.wdata = data_q;

endmodule

// File: source/irq_filter.sv
`timescale 1ns/1ps

`include "desc_proc_config.svh"

module irq_filter (
    input  logic                     clk,
    input  logic                     reset_n,
    input  logic                     irq_in,
    input  logic                     rx_fifo_empty,
    input  desc_proc_pkg::bus_word_t rx_fifo_data,
    output logic                     rx_fifo_rd_en,
    output logic                     irq_out,
    output logic                     tdma_ctl_pulse,
    bus_if.initiator                 bus
);

    desc_proc_pkg::irq_state_t state;

    logic irq_meta;
    logic irq_sync;
    logic irq_last;
    logic irq_rise;
    logic irq_pending;

    logic                     req_q;
    logic                     rd_done;
    logic                     tdma_hit;
    desc_proc_pkg::bus_word_t addr_q;
    desc_proc_pkg::bus_word_t desc_q;
    desc_proc_pkg::bus_word_t read_addr;

    // --------------------------------------------------
    // irq_in edge detect and pending flag
    // --------------------------------------------------
    assign irq_rise = irq_sync && !irq_last;

    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            irq_meta    <= 1'b0;
            irq_sync    <= 1'b0;
            irq_last    <= 1'b0;
            irq_pending <= 1'b0;
        end else begin
            irq_meta <= irq_in;
            irq_sync <= irq_meta;
            irq_last <= irq_sync;
            // A new edge wins over the clear from idle
            if (irq_rise) begin
                irq_pending <= 1'b1;
            end else if (state == desc_proc_pkg::IRQ_IDLE) begin
                irq_pending <= 1'b0;
            end
        end
    end

    // --------------------------------------------------
    // Read address for the current step
    // --------------------------------------------------
    always_comb begin
        case (state)
            desc_proc_pkg::IRQ_CAUSE:  read_addr = `DP_MAC_BASE + `DP_ASYNC_CAUSE_OFS;
            desc_proc_pkg::IRQ_ISR:    read_addr = `DP_MAC_BASE + `DP_ISR_OFS;
            desc_proc_pkg::IRQ_STATUS: read_addr = desc_q + `DP_RXS_STATUS11_OFS;
            desc_proc_pkg::IRQ_FCTL:   read_addr = desc_q + `DP_RXS_FCTL_OFS;
            default:                   read_addr = '0;
        endcase
    end

    assign rd_done = req_q && bus.done;

    // --------------------------------------------------
    // Filter FSM
    // --------------------------------------------------
    always_ff @(posedge clk or negedge reset_n) begin
        if (!reset_n) begin
            state          <= desc_proc_pkg::IRQ_IDLE;
            req_q          <= 1'b0;
            tdma_hit       <= 1'b0;
            rx_fifo_rd_en  <= 1'b0;
            tdma_ctl_pulse <= 1'b0;
            irq_out        <= 1'b0;
        end else begin
            rx_fifo_rd_en  <= 1'b0;
            tdma_ctl_pulse <= 1'b0;

            // Shared read handshake; req stays low for the entry cycle
            if (state inside {desc_proc_pkg::IRQ_CAUSE, desc_proc_pkg::IRQ_ISR,
                              desc_proc_pkg::IRQ_STATUS, desc_proc_pkg::IRQ_FCTL}) begin
                if (!req_q) begin
                    req_q <= 1'b1;
                end else if (bus.done) begin
                    req_q <= 1'b0;
                end
            end

            case (state)
                desc_proc_pkg::IRQ_IDLE: begin
                    if (irq_pending) begin
                        state <= desc_proc_pkg::IRQ_CAUSE;
                    end
                end
                desc_proc_pkg::IRQ_CAUSE: begin
                    if (rd_done) begin
                        if ((bus.rdata & `DP_INTR_MAC_IRQ) != '0) begin
                            state <= desc_proc_pkg::IRQ_ISR;
                        end else begin
                            irq_out <= 1'b1;
                            state   <= desc_proc_pkg::IRQ_PASS;
                        end
                    end
                end
                desc_proc_pkg::IRQ_ISR: begin
                    if (rd_done) begin
                        if ((bus.rdata & `DP_ISR_RXOK_MASK) != '0) begin
                            state <= desc_proc_pkg::IRQ_PEEK;
                        end else begin
                            irq_out <= 1'b1;
                            state   <= desc_proc_pkg::IRQ_PASS;
                        end
                    end
                end
                desc_proc_pkg::IRQ_PEEK: begin
                    // Empty FIFO ends the loop
                    if (rx_fifo_empty) begin
                        irq_out <= 1'b1;
                        state   <= desc_proc_pkg::IRQ_PASS;
                    end else begin
                        state <= desc_proc_pkg::IRQ_STATUS;
                    end
                end
                desc_proc_pkg::IRQ_STATUS: begin
                    if (rd_done) begin
                        if ((bus.rdata & `DP_RX_DONE) != '0) begin
                            state <= desc_proc_pkg::IRQ_FCTL;
                        end else begin
                            irq_out <= 1'b1;
                            state   <= desc_proc_pkg::IRQ_PASS;
                        end
                    end
                end
                desc_proc_pkg::IRQ_FCTL: begin
                    if (rd_done) begin
                        tdma_hit      <= (bus.rdata[15:0] & `DP_FCTL_TYPE_MASK) == `DP_FCTL_TDMA;
                        rx_fifo_rd_en <= 1'b1;
                        state         <= desc_proc_pkg::IRQ_POP;
                    end
                end
                desc_proc_pkg::IRQ_POP: begin
                    // FIFO advances here, so the next peek sees the new head
                    tdma_ctl_pulse <= tdma_hit;
                    state          <= desc_proc_pkg::IRQ_PEEK;
                end
                desc_proc_pkg::IRQ_PASS: begin
                    if (!irq_sync) begin
                        irq_out <= 1'b0;
                        state   <= desc_proc_pkg::IRQ_IDLE;
                    end
                end
                default: begin
                    state <= desc_proc_pkg::IRQ_IDLE;
                end
            endcase
        end
    end

    // Request address and descriptor pointer
    always_ff @(posedge clk) begin
        if (!req_q) begin
            addr_q <= read_addr;
        end
        if (state == desc_proc_pkg::IRQ_PEEK && !rx_fifo_empty) begin
            desc_q <= rx_fifo_data;
        end
    end

    // Reads only
    assign bus.req   = req_q;
    assign bus.write = 1'b0;
    assign bus.addr  = addr_q;
    assign bus.wdata = '0;

endmodule

// File: source/desc_processor.sv
`timescale 1ns/1ps

module desc_processor (
    input  logic                     clk,
    input  logic                     reset_n,
    // Transmit descriptor FIFO
    input  logic                     tx_fifo_empty,
    input  desc_proc_pkg::bus_word_t tx_fifo_data,
    output logic                     tx_fifo_rd_en,
    // Receive descriptor FIFO
    input  logic                     rx_fifo_empty,
    input  desc_proc_pkg::bus_word_t rx_fifo_data,
    output logic                     rx_fifo_rd_en,
    // Interrupt path
    input  logic                     irq_in,
    output logic                     irq_out,
    output logic                     tdma_ctl_pulse,
    // External bus master
    output logic                     bus_req,
    output logic                     bus_write,
    output desc_proc_pkg::bus_word_t bus_addr,
    output desc_proc_pkg::bus_word_t bus_wdata,
    input  desc_proc_pkg::bus_word_t bus_rdata,
    input  logic                     bus_cmplt
);

    bus_if tx_bus ();
    bus_if irq_bus ();

    // --------------------------------------------------
    // Initiators
    // --------------------------------------------------
    tx_desc_writer tx_desc_writer_inst (
        .clk        (clk),
        .reset_n    (reset_n),
        .fifo_empty (tx_fifo_empty),
        .fifo_data  (tx_fifo_data),
        .fifo_rd_en (tx_fifo_rd_en),
        .bus        (tx_bus.initiator)
    );

    irq_filter irq_filter_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .irq_in         (irq_in),
        .rx_fifo_empty  (rx_fifo_empty),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_rd_en  (rx_fifo_rd_en),
        .irq_out        (irq_out),
        .tdma_ctl_pulse (tdma_ctl_pulse),
        .bus            (irq_bus.initiator)
    );

    // --------------------------------------------------
    // Shared bus port
    // --------------------------------------------------
    bus_arbiter bus_arbiter_inst (
        .clk       (clk),
        .reset_n   (reset_n),
        .tx_port   (tx_bus.target),
        .irq_port  (irq_bus.target),
        .bus_req   (bus_req),
        .bus_write (bus_write),
        .bus_addr  (bus_addr),
        .bus_wdata (bus_wdata),
        .bus_rdata (bus_rdata),
        .bus_cmplt (bus_cmplt)
    );

endmodule

// File: dv/desc_processor_tb.sv
`timescale 1ns/1ps

module desc_processor_tb;

    // About ten times the longest test
    localparam int TIMEOUT_CYCLES = 4000;

    logic        clk;
    logic        reset_n;
    logic        tx_fifo_empty;
    logic [31:0] tx_fifo_data;
    logic        tx_fifo_rd_en;
    logic        rx_fifo_empty;
    logic [31:0] rx_fifo_data;
    logic        rx_fifo_rd_en;
    logic        irq_in;
    logic        irq_out;
    logic        tdma_ctl_pulse;
    logic        bus_req;
    logic        bus_write;
    logic [31:0] bus_addr;
    logic [31:0] bus_wdata;
    logic [31:0] bus_rdata;
    logic        bus_cmplt;

    // FIFO storage filled by the stimulus and drained by the DUT
    logic [31:0] tx_mem [16];
    logic [31:0] rx_mem [16];
    logic [3:0]  tx_wr;
    logic [3:0]  tx_rd;
    logic [3:0]  rx_wr;
    logic [3:0]  rx_rd;

    // Bus target state and access log
    logic [31:0] reg_mem [logic [31:0]];
    logic        bus_busy;
    int          wait_cnt;
    logic [31:0] rng;
    logic        cur_write;
    logic [31:0] cur_addr;
    logic [31:0] cur_wdata;
    logic        log_write [$];
    logic [31:0] log_addr [$];
    logic [31:0] log_data [$];

    // Expected traffic of the running test
    logic [31:0] exp_wr_addr [$];
    logic [31:0] exp_wr_data [$];
    logic [31:0] exp_rd_addr [$];
    int          exp_pops;
    int          exp_tdma;
    int          log_base;
    int          tx_base;
    int          rx_base;
    int          tdma_base;

    int cycles;
    int tx_pops;
    int rx_pops;
    int tdma_pulses;
    int hold_off;
    int checks;
    int errors;
    int mon_errors;
    int reset_errors;
    int hold_errors;
    int total;

    desc_processor desc_processor_inst (
        .clk            (clk),
        .reset_n        (reset_n),
        .tx_fifo_empty  (tx_fifo_empty),
        .tx_fifo_data   (tx_fifo_data),
        .tx_fifo_rd_en  (tx_fifo_rd_en),
        .rx_fifo_empty  (rx_fifo_empty),
        .rx_fifo_data   (rx_fifo_data),
        .rx_fifo_rd_en  (rx_fifo_rd_en),
        .irq_in         (irq_in),
        .irq_out        (irq_out),
        .tdma_ctl_pulse (tdma_ctl_pulse),
        .bus_req        (bus_req),
        .bus_write      (bus_write),
        .bus_addr       (bus_addr),
        .bus_wdata      (bus_wdata),
        .bus_rdata      (bus_rdata),
        .bus_cmplt      (bus_cmplt)
    );

    initial begin
        clk = 1'b0;
        forever #4 clk = ~clk;
    end

    function automatic logic [31:0] xorshift(input logic [31:0] x);
        logic [31:0] y;
        y = x;
        y = y ^ (y << 13);
        y = y ^ (y >> 17);
        y = y ^ (y << 5);
        return y;
    endfunction

    function automatic logic [31:0] read_word(input logic [31:0] a);
        if (reg_mem.exists(a)) begin
            return reg_mem[a];
        end
        return 32'h0;
    endfunction

    // --------------------------------------------------
    // First-word fall-through FIFO models
    // --------------------------------------------------
    initial begin
        logic [3:0] tx_next;
        logic [3:0] rx_next;
        tx_rd = 4'd0;
        rx_rd = 4'd0;
        tx_fifo_empty = 1'b1;
        tx_fifo_data = 32'h0;
        rx_fifo_empty = 1'b1;
        rx_fifo_data = 32'h0;
        forever begin
            @(posedge clk);
            tx_next = tx_rd + {3'd0, tx_fifo_rd_en};
            rx_next = rx_rd + {3'd0, rx_fifo_rd_en};
            tx_rd         <= tx_next;
            tx_fifo_empty <= (tx_next == tx_wr);
            tx_fifo_data  <= (tx_next == tx_wr) ? 32'h0 : tx_mem[tx_next];
            rx_rd         <= rx_next;
            rx_fifo_empty <= (rx_next == rx_wr);
            rx_fifo_data  <= (rx_next == rx_wr) ? 32'h0 : rx_mem[rx_next];
        end
    end

    // --------------------------------------------------
    // Bus target with 1 to 6 cycles of latency
    // --------------------------------------------------
    initial begin
        bus_rdata = 32'h0;
        bus_cmplt = 1'b0;
        bus_busy = 1'b0;
        wait_cnt = 0;
        rng = 32'd67719;
        forever begin
            @(posedge clk);
            bus_cmplt <= 1'b0;
            if (bus_busy) begin
                if (wait_cnt == 0) begin
                    bus_cmplt <= 1'b1;
                    bus_busy  <= 1'b0;
                    bus_rdata <= cur_write ? 32'h0 : read_word(cur_addr);
                    log_write.push_back(cur_write);
                    log_addr.push_back(cur_addr);
                    log_data.push_back(cur_wdata);
                end else begin
                    wait_cnt <= wait_cnt - 1;
                end
            end else if (bus_req && !bus_cmplt) begin
                rng = xorshift(rng);
                bus_busy  <= 1'b1;
                wait_cnt  <= rng % 6;
                cur_write <= bus_write;
                cur_addr  <= bus_addr;
                cur_wdata <= bus_wdata;
            end
        end
    end

    // Event counters and arbiter back-pressure watch
    initial begin
        forever begin
            @(posedge clk);
            cycles <= cycles + 1;
            if (tx_fifo_rd_en) begin
                tx_pops <= tx_pops + 1;
            end
            if (rx_fifo_rd_en) begin
                rx_pops <= rx_pops + 1;
            end
            if (tdma_ctl_pulse) begin
                tdma_pulses <= tdma_pulses + 1;
            end
            if (reset_n && !bus_busy && !bus_req &&
                (desc_processor_inst.tx_desc_writer_inst.req_q ||
                 desc_processor_inst.irq_filter_inst.req_q)) begin
                hold_off = hold_off + 1;
            end else begin
                hold_off = 0;
            end
            assert (hold_off <= 1) else begin
                mon_errors = mon_errors + 1;
                $display("Bus request held back %0d cycles while an initiator waits",
                         hold_off);
            end
        end
    end

    initial begin
        while (cycles < TIMEOUT_CYCLES) @(posedge clk);
        $display("Timeout: the tests did not complete within %0d cycles", TIMEOUT_CYCLES);
        $display("Some tests failed");
        $finish;
    end

    assert property (@(posedge clk) !reset_n |->
        !(bus_req || tx_fifo_rd_en || rx_fifo_rd_en || irq_out || tdma_ctl_pulse))
    else begin
        reset_errors = reset_errors + 1;
        $display("ERROR reset_outputs expected 0 actual %b",
                 {bus_req, tx_fifo_rd_en, rx_fifo_rd_en, irq_out, tdma_ctl_pulse});
    end

    // Outstanding request holds its fields until bus_cmplt
    assert property (@(posedge clk) disable iff (!reset_n) bus_busy |->
        (bus_req && bus_write == cur_write && bus_addr == cur_addr && bus_wdata == cur_wdata))
    else begin
        hold_errors = hold_errors + 1;
        $display("ERROR bus_hold expected %h actual %h", cur_addr, bus_addr);
    end

    // --------------------------------------------------
    // Checks and stimulus helpers
    // --------------------------------------------------
    task automatic check_eq(input string name, input logic [31:0] exp, input logic [31:0] act);
        checks = checks + 1;
        assert (act === exp) else begin
            errors = errors + 1;
            $display("ERROR %s expected %h actual %h", name, exp, act);
        end
    endtask

    task automatic check_log(input string name);
        int wi;
        int ri;
        int i;
        wi = 0;
        ri = 0;
        for (i = log_base; i < log_addr.size(); i++) begin
            if (log_write[i]) begin
                if (wi < exp_wr_addr.size()) begin
                    check_eq({name, " write addr"}, exp_wr_addr[wi], log_addr[i]);
                    check_eq({name, " write data"}, exp_wr_data[wi], log_data[i]);
                end
                wi++;
            end else begin
                if (ri < exp_rd_addr.size()) begin
                    check_eq({name, " read addr"}, exp_rd_addr[ri], log_addr[i]);
                end
                ri++;
            end
        end
        check_eq({name, " write count"}, exp_wr_addr.size(), wi);
        check_eq({name, " read count"}, exp_rd_addr.size(), ri);
    endtask

    task automatic check_counts(input string name);
        check_eq({name, " rx pops"}, exp_pops, rx_pops - rx_base);
        check_eq({name, " tdma pulses"}, exp_tdma, tdma_pulses - tdma_base);
    endtask

    task automatic start_test();
        exp_wr_addr.delete();
        exp_wr_data.delete();
        exp_rd_addr.delete();
        exp_pops = 0;
        exp_tdma = 0;
        log_base = log_addr.size();
        tx_base = tx_pops;
        rx_base = rx_pops;
        tdma_base = tdma_pulses;
    endtask

    task automatic push_tx(input logic [31:0] word);
        @(posedge clk);
        tx_mem[tx_wr] <= word;
        tx_wr         <= tx_wr + 4'd1;
    endtask

    task automatic push_rx(input logic [31:0] word);
        @(posedge clk);
        rx_mem[rx_wr] <= word;
        rx_wr         <= rx_wr + 4'd1;
    endtask

    task automatic load_tx_pairs(input int n, input logic [31:0] addr0);
        logic [31:0] a;
        logic [31:0] d;
        int k;
        a = addr0;
        for (k = 0; k < n; k++) begin
            d = {a[15:0], ~a[15:0]};
            push_tx(a);
            push_tx(d);
            exp_wr_addr.push_back(a);
            exp_wr_data.push_back(d);
            a = a + 32'h0000_0010;
        end
    endtask

    // Descriptor words at +44 and +48 with the reads and pops they imply
    task automatic add_desc(input logic [31:0] desc, input logic [31:0] status,
                            input logic [31:0] fctl, input logic is_tdma);
        reg_mem[desc + 32'd44] = status;
        reg_mem[desc + 32'd48] = fctl;
        push_rx(desc);
        exp_rd_addr.push_back(desc + 32'd44);
        if (status[0]) begin
            exp_rd_addr.push_back(desc + 32'd48);
            exp_pops = exp_pops + 1;
            if (is_tdma) begin
                exp_tdma = exp_tdma + 1;
            end
        end
    endtask

    task automatic raise_irq();
        @(posedge clk);
        irq_in <= 1'b1;
        while (irq_out !== 1'b1) @(posedge clk);
    endtask

    task automatic drop_irq();
        @(posedge clk);
        irq_in <= 1'b0;
        while (irq_out !== 1'b0) @(posedge clk);
    endtask

    // --------------------------------------------------
    // Test sequence
    // --------------------------------------------------
    initial begin
        reset_n = 1'b0;
        irq_in = 1'b0;
        tx_wr = 4'd0;
        rx_wr = 4'd0;
        repeat (16) @(posedge clk);
        reset_n <= 1'b1;
        @(posedge clk);
        check_eq("reset_release", 32'd0,
                 {27'd0, bus_req, tx_fifo_rd_en, rx_fifo_rd_en, irq_out, tdma_ctl_pulse});

        // Three transmit write-backs
        start_test();
        load_tx_pairs(3, 32'h6000_8000);
        while (log_addr.size() < log_base + 3) @(posedge clk);
        check_log("tx_writes");
        check_eq("tx_writes tx pops", 32'd6, tx_pops - tx_base);

        // Cause register without the MAC bit
        start_test();
        reg_mem[32'h6000_4038] = 32'h0000_0001;
        exp_rd_addr.push_back(32'h6000_4038);
        raise_irq();
        repeat (4) @(posedge clk);
        check_eq("irq_no_mac irq_out held", 32'd1, {31'd0, irq_out});
        check_log("irq_no_mac");
        check_counts("irq_no_mac");
        drop_irq();

        // Two received frames, one of them TDMA control
        start_test();
        reg_mem[32'h6000_4038] = 32'h0000_0002;
        reg_mem[32'h6000_0080] = 32'h0000_0001;
        exp_rd_addr.push_back(32'h6000_4038);
        exp_rd_addr.push_back(32'h6000_0080);
        add_desc(32'h1000_0000, 32'h0000_0001, 32'h0000_0304, 1'b1);
        add_desc(32'h1000_0200, 32'h0000_0001, 32'h0000_4108, 1'b0);
        raise_irq();
        check_log("irq_rx_peek");
        check_counts("irq_rx_peek");
        drop_irq();

        // Writes and an interrupt sharing the bus
        start_test();
        reg_mem[32'h6000_0080] = 32'h0000_0002;
        exp_rd_addr.push_back(32'h6000_4038);
        exp_rd_addr.push_back(32'h6000_0080);
        load_tx_pairs(3, 32'h6000_9000);
        add_desc(32'h1000_0400, 32'h0000_0001, 32'h0000_0004, 1'b1);
        // RxDone clear ends the loop
        add_desc(32'h1000_0600, 32'h0000_0000, 32'h0000_0008, 1'b0);
        raise_irq();
        while (log_addr.size() < log_base + 8) @(posedge clk);
        check_log("shared_bus");
        check_counts("shared_bus");
        drop_irq();

        total = errors + mon_errors + reset_errors + hold_errors;
        $display("Checks: %0d, check errors: %0d, monitor errors: %0d, assertion errors: %0d",
                 checks, errors, mon_errors, reset_errors + hold_errors);
        if (total == 0) begin
            $display("All tests passed");
        end else begin
            $display("Some tests failed");
        end
        $finish;
    end

endmodule

// File: vlog.f
+incdir+source
source/desc_proc_pkg.sv
source/bus_if.sv
source/bus_arbiter.sv
source/tx_desc_writer.sv
source/irq_filter.sv
source/desc_processor.sv
dv/desc_processor_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    -f vlog.f \
    --top-module desc_processor_tb \
    -o desc_processor_sim

./obj_dir/desc_processor_sim 2>&1 | tee sim.log

if grep -q "Some tests failed" sim.log; then
    echo "Simulation reported failures"
    exit 1
fi
if ! grep -q "All tests passed" sim.log; then
    echo "Simulation ended without a result"
    exit 1
fi
